// ==== verilog/mips_isa_pkg.sv ====
// mips-style encodings; only the opcodes and funct codes this execute stage decodes are listed
package mips_isa_pkg;

	// field positions inside the sign-extended immediate
	localparam int FUNCT_LSB = 0;
	localparam int FUNCT_W   = 6;
	localparam int SHAMT_LSB = 6;
	localparam int SHAMT_W   = 5;

	// =========================================================================
	// primary opcodes
	// =========================================================================
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_JAL   = 6'h03,
		OP_ADDI  = 6'h08,
		OP_ADDIU = 6'h09,
		OP_SLTI  = 6'h0a,
		OP_SLTIU = 6'h0b,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_XORI  = 6'h0e,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_t;

	// =========================================================================
	// r-type function codes
	// =========================================================================
	typedef enum logic [FUNCT_W-1:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_SRA  = 6'h03,
		FN_SLLV = 6'h04,
		FN_SRLV = 6'h06,
		FN_SRAV = 6'h07,
		FN_ADD  = 6'h20,
		FN_ADDU = 6'h21,
		FN_SUB  = 6'h22,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_t;

	// internal alu operations, all sixteen codes in use
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
		ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV,
		ALU_SRLV, ALU_SRAV, ALU_LUI, ALU_PASSA
	} alu_op_t;

endpackage

// ==== verilog/mips_pipe_pkg.sv ====
// pipeline widths for a 32-bit, 32-register datapath; register 0 is hardwired and never forwarded
package mips_pipe_pkg;

	// =========================================================================
	// datapath widths
	// =========================================================================
	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;

	typedef logic [DATA_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// =========================================================================
	// forwarding
	// =========================================================================

	// where an alu source operand comes from
	typedef enum logic [1:0] {
		// register file value read in decode
		FWD_REG = 2'd0,
		// result sitting in the memory stage
		FWD_MEM = 2'd1,
		// value being written back
		FWD_WB  = 2'd2
	} fwd_sel_t;

	// $zero, writes to it are discarded
	localparam reg_addr_t REG_ZERO = '0;

endpackage

// ==== verilog/ex_fwd_if.sv ====
// later-stage forwarding info; driven whole by the execute top, no handshake, values valid every cycle
`timescale 1ns/1ps

interface ex_fwd_if import mips_pipe_pkg::*; ();

	// memory stage
	reg_addr_t mem_rd;
	logic      mem_we;
	word_t     mem_data;

	// writeback stage
	reg_addr_t wb_rd;
	logic      wb_we;
	word_t     wb_data;

	// hazard detection only needs addresses and enables
	modport hazard (
		input mem_rd,
		input mem_we,
		input wb_rd,
		input wb_we
	);

	// operand muxes only need the data
	modport operand (
		input mem_data,
		input wb_data
	);

endinterface

// ==== verilog/ex_forward.sv ====
// combinational forwarding unit; memory stage wins over writeback, writes to $zero never forward
`timescale 1ns/1ps

module ex_forward import mips_pipe_pkg::*; (
	ex_fwd_if.hazard  fwd,
	input  reg_addr_t i_rs_addr,
	input  reg_addr_t i_rt_addr,
	output fwd_sel_t  o_fwd_a,
	output fwd_sel_t  o_fwd_b
);

	// precedence rule for one source register
	function automatic fwd_sel_t pick_source(
		input reg_addr_t src,
		input logic      mem_we,
		input reg_addr_t mem_rd,
		input logic      wb_we,
		input reg_addr_t wb_rd
	);
		fwd_sel_t sel;
		sel = FWD_REG;
		if (mem_we && (mem_rd != REG_ZERO) && (mem_rd == src)) begin
			sel = FWD_MEM;
		end else if (wb_we && (wb_rd != REG_ZERO) && (wb_rd == src)) begin
			sel = FWD_WB;
		end
		return sel;
	endfunction

	always_comb begin
		o_fwd_a = pick_source(i_rs_addr, fwd.mem_we, fwd.mem_rd, fwd.wb_we, fwd.wb_rd);
		o_fwd_b = pick_source(i_rt_addr, fwd.mem_we, fwd.mem_rd, fwd.wb_we, fwd.wb_rd);
	end

endmodule

// ==== verilog/ex_operand_sel.sv ====
// operand steering: forwarding muxes, alu a/b source and destination choice; purely combinational
`timescale 1ns/1ps

module ex_operand_sel import mips_pipe_pkg::*; (
	ex_fwd_if.operand fwd,
	input  fwd_sel_t  i_fwd_a,
	input  fwd_sel_t  i_fwd_b,
	input  word_t     i_rs_data,
	input  word_t     i_rt_data,
	input  word_t     i_imm_ext,
	input  word_t     i_pc4,
	input  logic      i_alu_src,
	input  logic      i_alu_pc4,
	input  logic      i_reg_dst,
	input  reg_addr_t i_rt_addr,
	input  reg_addr_t i_rd_addr,
	output word_t     o_alu_a,
	output word_t     o_alu_b,
	output word_t     o_store_data,
	output reg_addr_t o_dest
);

	word_t rs_fwd;
	word_t rt_fwd;

	// three-way forwarding mux, unused code falls back to the register value
	function automatic word_t fwd_mux(
		input fwd_sel_t sel,
		input word_t    reg_val,
		input word_t    mem_val,
		input word_t    wb_val
	);
		word_t val;
		case (sel)
			FWD_MEM: val = mem_val;
			FWD_WB:  val = wb_val;
			default: val = reg_val;
		endcase
		return val;
	endfunction

	// =========================================================================
	// forwarded register operands
	// =========================================================================
	always_comb begin
		rs_fwd = fwd_mux(i_fwd_a, i_rs_data, fwd.mem_data, fwd.wb_data);
		rt_fwd = fwd_mux(i_fwd_b, i_rt_data, fwd.mem_data, fwd.wb_data);
	end

	// =========================================================================
	// alu sources and destination
	// =========================================================================

	// jal puts the return address through the alu
	assign o_alu_a = i_alu_pc4 ? i_pc4 : rs_fwd;
	assign o_alu_b = i_alu_src ? i_imm_ext : rt_fwd;

	// stores always take rt, even when b carries the offset
	assign o_store_data = rt_fwd;

	// rd for r-type, rt for immediate forms
	assign o_dest = i_reg_dst ? i_rd_addr : i_rt_addr;

endmodule

// ==== verilog/ex_alu_decode.sv ====
// opcode/funct to alu operation; unknown opcodes and funct codes decode to add
`timescale 1ns/1ps

module ex_alu_decode import mips_isa_pkg::*; (
	input  opcode_t i_opcode,
	input  funct_t  i_funct,
	output alu_op_t o_alu_op
);

	// r-type operation from the funct field
	function automatic alu_op_t decode_funct(input funct_t funct);
		alu_op_t op;
		case (funct)
			FN_ADD, FN_ADDU: op = ALU_ADD;
			FN_SUB, FN_SUBU: op = ALU_SUB;
			FN_AND:          op = ALU_AND;
			FN_OR:           op = ALU_OR;
			FN_XOR:          op = ALU_XOR;
			FN_NOR:          op = ALU_NOR;
			FN_SLT:          op = ALU_SLT;
			FN_SLTU:         op = ALU_SLTU;
			FN_SLL:          op = ALU_SLL;
			FN_SRL:          op = ALU_SRL;
			FN_SRA:          op = ALU_SRA;
			FN_SLLV:         op = ALU_SLLV;
			FN_SRLV:         op = ALU_SRLV;
			FN_SRAV:         op = ALU_SRAV;
			default:         op = ALU_ADD;
		endcase
		return op;
	endfunction

	// =========================================================================
	// main decode
	// =========================================================================
	always_comb begin
		case (i_opcode)
			OP_RTYPE: o_alu_op = decode_funct(i_funct);

			// address calculation shares the adder
			OP_ADDI, OP_ADDIU, OP_LW, OP_SW: o_alu_op = ALU_ADD;

			OP_SLTI:  o_alu_op = ALU_SLT;
			OP_SLTIU: o_alu_op = ALU_SLTU;
			OP_ANDI:  o_alu_op = ALU_AND;
			OP_ORI:   o_alu_op = ALU_OR;
			OP_XORI:  o_alu_op = ALU_XOR;
			OP_LUI:   o_alu_op = ALU_LUI;

			// a already holds pc+4 for jal
			OP_JAL:   o_alu_op = ALU_PASSA;

			default:  o_alu_op = ALU_ADD;
		endcase
	end

endmodule

// ==== verilog/ex_alu.sv ====
// 32-bit combinational alu; no overflow detection, shifts act on b, variable shifts take a[4:0]
`timescale 1ns/1ps

module ex_alu import mips_isa_pkg::*, mips_pipe_pkg::*; (
	input  word_t              i_a,
	input  word_t              i_b,
	input  logic [SHAMT_W-1:0] i_shamt,
	input  alu_op_t            i_op,
	output word_t              o_result
);

	localparam int HALF_W = DATA_W / 2;

	logic [SHAMT_W-1:0] var_shamt;
	logic               lt_signed;
	logic               lt_unsigned;

	// variable shift amount from rs
	assign var_shamt = i_a[SHAMT_W-1:0];

	// =========================================================================
	// comparisons
	// =========================================================================
	assign lt_signed   = $signed(i_a) < $signed(i_b);
	assign lt_unsigned = i_a < i_b;

	// =========================================================================
	// result select
	// =========================================================================
	always_comb begin
		case (i_op)
			ALU_ADD:  o_result = i_a + i_b;
			ALU_SUB:  o_result = i_a - i_b;
			ALU_AND:  o_result = i_a & i_b;
			ALU_OR:   o_result = i_a | i_b;
			ALU_XOR:  o_result = i_a ^ i_b;
			ALU_NOR:  o_result = ~(i_a | i_b);

			// set-less-than gives a clean 0 or 1
			ALU_SLT:  o_result = {{(DATA_W-1){1'b0}}, lt_signed};
			ALU_SLTU: o_result = {{(DATA_W-1){1'b0}}, lt_unsigned};

			// fixed shifts
			ALU_SLL:  o_result = i_b << i_shamt;
			ALU_SRL:  o_result = i_b >> i_shamt;
			ALU_SRA:  o_result = word_t'($signed(i_b) >>> i_shamt);

			// variable shifts
			ALU_SLLV: o_result = i_b << var_shamt;
			ALU_SRLV: o_result = i_b >> var_shamt;
			ALU_SRAV: o_result = word_t'($signed(i_b) >>> var_shamt);

			// low half of the immediate into the upper half
			ALU_LUI:  o_result = {i_b[HALF_W-1:0], {HALF_W{1'b0}}};

			ALU_PASSA: o_result = i_a;
			default:   o_result = i_a + i_b;
		endcase
	end

endmodule

// ==== verilog/mips_execute.sv ====
// execute stage with EX/MEM register; one instruction per cycle, no stall or flush input, 1-cycle latency
`timescale 1ns/1ps

module mips_execute import mips_isa_pkg::*, mips_pipe_pkg::*; (
	input  logic      i_clk,
	input  logic      i_nrst,
	// operands from the ID/EX register
	input  word_t     i_pc4,
	input  word_t     i_rs_data,
	input  word_t     i_rt_data,
	input  word_t     i_imm_ext,
	input  reg_addr_t i_rs_addr,
	input  reg_addr_t i_rt_addr,
	input  reg_addr_t i_rd_addr,
	// forwarding from memory and writeback
	input  word_t     i_mem_fwd_data,
	input  word_t     i_wb_fwd_data,
	input  reg_addr_t i_mem_fwd_addr,
	input  reg_addr_t i_wb_fwd_addr,
	input  logic      i_mem_fwd_we,
	input  logic      i_wb_fwd_we,
	// execute controls
	input  opcode_t   i_alu_op,
	input  logic      i_alu_src,
	input  logic      i_reg_dst,
	input  logic      i_alu_pc4,
	// memory and writeback controls, passed along
	input  logic      i_mem_read,
	input  logic      i_mem_write,
	input  logic [1:0] i_load_sel,
	input  logic      i_mem_to_reg,
	input  logic      i_reg_write,
	// EX/MEM register
	output word_t     o_alu_result,
	output word_t     o_store_data,
	output reg_addr_t o_dest_addr,
	output logic      o_mem_read,
	output logic      o_mem_write,
	output logic [1:0] o_load_sel,
	output logic      o_mem_to_reg,
	output logic      o_reg_write
);

	fwd_sel_t           fwd_a;
	fwd_sel_t           fwd_b;
	word_t              alu_a;
	word_t              alu_b;
	word_t              alu_result;
	word_t              store_data;
	reg_addr_t          dest;
	alu_op_t            alu_sel;
	funct_t             funct;
	logic [SHAMT_W-1:0] shamt;

	// =========================================================================
	// forwarding bus
	// =========================================================================
	ex_fwd_if fwd_bus ();

	assign fwd_bus.mem_rd   = i_mem_fwd_addr;
	assign fwd_bus.mem_we   = i_mem_fwd_we;
	assign fwd_bus.mem_data = i_mem_fwd_data;
	assign fwd_bus.wb_rd    = i_wb_fwd_addr;
	assign fwd_bus.wb_we    = i_wb_fwd_we;
	assign fwd_bus.wb_data  = i_wb_fwd_data;

	// funct and shamt live in the low bits of the sign-extended immediate
	assign funct = funct_t'(i_imm_ext[FUNCT_LSB +: FUNCT_W]);
	assign shamt = i_imm_ext[SHAMT_LSB +: SHAMT_W];

	// =========================================================================
	// datapath
	// =========================================================================
	ex_forward u_forward (
		.fwd       (fwd_bus),
		.i_rs_addr (i_rs_addr),
		.i_rt_addr (i_rt_addr),
		.o_fwd_a   (fwd_a),
		.o_fwd_b   (fwd_b)
	);

	ex_operand_sel u_operand_sel (
		.fwd          (fwd_bus),
		.i_fwd_a      (fwd_a),
		.i_fwd_b      (fwd_b),
		.i_rs_data    (i_rs_data),
		.i_rt_data    (i_rt_data),
		.i_imm_ext    (i_imm_ext),
		.i_pc4        (i_pc4),
		.i_alu_src    (i_alu_src),
		.i_alu_pc4    (i_alu_pc4),
		.i_reg_dst    (i_reg_dst),
		.i_rt_addr    (i_rt_addr),
		.i_rd_addr    (i_rd_addr),
		.o_alu_a      (alu_a),
		.o_alu_b      (alu_b),
		.o_store_data (store_data),
		.o_dest       (dest)
	);

	ex_alu_decode u_alu_decode (
		.i_opcode (i_alu_op),
		.i_funct  (funct),
		.o_alu_op (alu_sel)
	);

	ex_alu u_alu (
		.i_a      (alu_a),
		.i_b      (alu_b),
		.i_shamt  (shamt),
		.i_op     (alu_sel),
		.o_result (alu_result)
	);

	// =========================================================================
	// EX/MEM register
	// =========================================================================
	always_ff @(posedge i_clk or negedge i_nrst) begin
		if (!i_nrst) begin
			o_alu_result <= '0;
			o_store_data <= '0;
			o_dest_addr  <= '0;
			o_mem_read   <= 1'b0;
			o_mem_write  <= 1'b0;
			o_load_sel   <= '0;
			o_mem_to_reg <= 1'b0;
			o_reg_write  <= 1'b0;
		end else begin
			o_alu_result <= alu_result;
			o_store_data <= store_data;
			o_dest_addr  <= dest;
			o_mem_read   <= i_mem_read;
			o_mem_write  <= i_mem_write;
			o_load_sel   <= i_load_sel;
			o_mem_to_reg <= i_mem_to_reg;
			o_reg_write  <= i_reg_write;
		end
	end

endmodule

// ==== verification/mips_execute_chk.sv ====
// bound into mips_execute; i_dest taps the internal destination mux, checks hold only on i_clk edges
`timescale 1ns/1ps

module mips_execute_chk import mips_pipe_pkg::*; (
	input logic       i_clk,
	input logic       i_nrst,
	input logic       i_mem_read,
	input logic       i_mem_write,
	input logic [1:0] i_load_sel,
	input logic       i_mem_to_reg,
	input logic       i_reg_write,
	input reg_addr_t  i_dest,
	input word_t      o_alu_result,
	input word_t      o_store_data,
	input reg_addr_t  o_dest_addr,
	input logic       o_mem_read,
	input logic       o_mem_write,
	input logic [1:0] o_load_sel,
	input logic       o_mem_to_reg,
	input logic       o_reg_write
);

	// number of assertion failures so far
	int fail_count = 0;

	// everything held at zero while reset is low
	a_reset_zero: assert property (@(posedge i_clk) !i_nrst |-> (o_alu_result == '0
		&& o_store_data == '0 && o_dest_addr == '0 && !o_mem_read && !o_mem_write
		&& o_load_sel == '0 && !o_mem_to_reg && !o_reg_write))
		else begin
			fail_count++;
			$error("outputs not zero during reset");
		end

	// controls and destination appear one cycle later
	a_ctrl_pass: assert property (@(posedge i_clk) disable iff (!i_nrst)
		1'b1 |=> {o_mem_read, o_mem_write, o_load_sel, o_mem_to_reg, o_reg_write, o_dest_addr}
		== $past({i_mem_read, i_mem_write, i_load_sel, i_mem_to_reg, i_reg_write, i_dest}))
		else begin
			fail_count++;
			$error("control or destination not passed through in one cycle");
		end

	a_rw_excl: assert property (@(posedge i_clk) disable iff (!i_nrst)
		!(i_mem_read && i_mem_write) |=> !(o_mem_read && o_mem_write))
		else begin
			fail_count++;
			$error("read and write both active at the memory stage");
		end

endmodule

// ==== verification/tb_mips_execute.sv ====
// drives the ID/EX inputs on falling edges; table rows share fixed pc4 and forwarding data
`timescale 1ns/1ps

module tb_mips_execute import mips_isa_pkg::*, mips_pipe_pkg::*;;

	typedef struct packed {
		opcode_t op;
		word_t imm, rs, rt, pc4, md, wd;
		reg_addr_t rsa, rta, rda, ma, wa;
		logic mwe, wwe, src, dst, pc4f, mrd, mwr;
		logic [1:0] lsel;
		logic m2r, rw;
	} vec_t;

	typedef struct packed {
		opcode_t op;
		word_t imm, rs, rt;
		reg_addr_t rsa, rta, ma;
		logic mwe;
		reg_addr_t wa;
		logic wwe;
		word_t exp;
	} row_t;

	logic i_clk, i_nrst, i_mem_fwd_we, i_wb_fwd_we, i_alu_src, i_reg_dst, i_alu_pc4;
	logic i_mem_read, i_mem_write, i_mem_to_reg, i_reg_write;
	logic o_mem_read, o_mem_write, o_mem_to_reg, o_reg_write;
	logic [1:0] i_load_sel, o_load_sel;
	word_t i_pc4, i_rs_data, i_rt_data, i_imm_ext, i_mem_fwd_data, i_wb_fwd_data;
	word_t o_alu_result, o_store_data;
	reg_addr_t i_rs_addr, i_rt_addr, i_rd_addr, i_mem_fwd_addr, i_wb_fwd_addr, o_dest_addr;
	opcode_t i_alu_op;
	logic [31:0] lfsr = 32'hb97328a1;
	vec_t v;
	row_t rows [34];
	opcode_t ops [12] = '{OP_RTYPE, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI,
		OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_SW, OP_JAL};
	logic [5:0] fns [16] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
		6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07};

	bind mips_execute mips_execute_chk u_chk (.i_dest(dest), .*);

	mips_execute uut (.*);

	always #5 i_clk = ~i_clk;

	// fibonacci lfsr with taps 32 22 2 1, stepped once per bit taken
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// =========================================================================
	// reference model
	// =========================================================================
	function automatic word_t fwd_val(input reg_addr_t a, input word_t r, input vec_t x);
		if (x.mwe && x.ma != 5'd0 && x.ma == a) return x.md;
		if (x.wwe && x.wa != 5'd0 && x.wa == a) return x.wd;
		return r;
	endfunction

	function automatic word_t ref_result(input vec_t x);
		word_t a;
		word_t b;
		logic [4:0] sh;
		a = x.pc4f ? x.pc4 : fwd_val(x.rsa, x.rs, x);
		b = x.src ? x.imm : fwd_val(x.rta, x.rt, x);
		sh = x.imm[10:6];
		case (x.op)
			OP_RTYPE: case (x.imm[5:0])
				6'h22, 6'h23: return a - b;
				6'h24: return a & b;
				6'h25: return a | b;
				6'h26: return a ^ b;
				6'h27: return ~(a | b);
				6'h2a: return {31'b0, $signed(a) < $signed(b)};
				6'h2b: return {31'b0, a < b};
				6'h00: return b << sh;
				6'h02: return b >> sh;
				6'h03: return $signed(b) >>> sh;
				6'h04: return b << a[4:0];
				6'h06: return b >> a[4:0];
				6'h07: return $signed(b) >>> a[4:0];
				default: return a + b;
			endcase
			OP_SLTI: return {31'b0, $signed(a) < $signed(b)};
			OP_SLTIU: return {31'b0, a < b};
			OP_ANDI: return a & b;
			OP_ORI: return a | b;
			OP_XORI: return a ^ b;
			OP_LUI: return {b[15:0], 16'h0};
			OP_JAL: return a;
			default: return a + b;
		endcase
	endfunction

	// =========================================================================
	// failure reporting and compares
	// =========================================================================
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
			report_failure($sformatf("FAILED t=%0t %s exp %h got %h", $time, name, exp, act));
	endtask

	task automatic check_reg_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
		if (act !== exp)
			report_failure($sformatf("FAILED t=%0t %s exp %h got %h", $time, name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			report_failure($sformatf("FAILED t=%0t %s exp %b got %b", $time, name, exp, act));
	endtask

	task automatic check_load_sel(input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp)
			report_failure($sformatf("FAILED t=%0t o_load_sel exp %b got %b", $time, exp, act));
	endtask

	// watch the bound checker
	always @(uut.u_chk.fail_count) begin
		if (uut.u_chk.fail_count != 0)
			report_failure("an assertion in mips_execute_chk failed");
	end

	task automatic wait_edge(input bit rise);
		bit seen;
		seen = 1'b0;
		fork
			begin
				if (rise) @(posedge i_clk);
				else @(negedge i_clk);
				seen = 1'b1;
			end
			for (int t = 0; t < 100 && !seen; t++) #1;
		join_any
		disable fork;
		if (!seen) report_failure("clock edge did not arrive within 100 ns");
	endtask

	task automatic check_outputs(input vec_t x, input word_t exp_res);
		check_word("o_alu_result", exp_res, o_alu_result);
		check_word("o_store_data", fwd_val(x.rta, x.rt, x), o_store_data);
		check_reg_addr("o_dest_addr", x.dst ? x.rda : x.rta, o_dest_addr);
		check_flag("o_mem_read", x.mrd, o_mem_read);
		check_flag("o_mem_write", x.mwr, o_mem_write);
		check_load_sel(x.lsel, o_load_sel);
		check_flag("o_mem_to_reg", x.m2r, o_mem_to_reg);
		check_flag("o_reg_write", x.rw, o_reg_write);
	endtask

	task automatic apply(input vec_t x);
		i_alu_op = x.op;
		{i_imm_ext, i_rs_data, i_rt_data, i_pc4} = {x.imm, x.rs, x.rt, x.pc4};
		{i_mem_fwd_data, i_wb_fwd_data, i_rs_addr, i_rt_addr} = {x.md, x.wd, x.rsa, x.rta};
		{i_rd_addr, i_mem_fwd_addr, i_wb_fwd_addr} = {x.rda, x.ma, x.wa};
		{i_mem_fwd_we, i_wb_fwd_we, i_alu_src, i_reg_dst} = {x.mwe, x.wwe, x.src, x.dst};
		{i_alu_pc4, i_mem_read, i_mem_write, i_load_sel} = {x.pc4f, x.mrd, x.mwr, x.lsel};
		{i_mem_to_reg, i_reg_write} = {x.m2r, x.rw};
	endtask

	// table row widened to a full vector with controls from the row number
	function automatic vec_t to_vec(input row_t r, input int i);
		vec_t x;
		x = '0;
		x.op = r.op;
		{x.imm, x.rs, x.rt, x.rsa, x.rta} = {r.imm, r.rs, r.rt, r.rsa, r.rta};
		{x.ma, x.mwe, x.wa, x.wwe} = {r.ma, r.mwe, r.wa, r.wwe};
		{x.pc4, x.md, x.wd, x.rda} = {32'h1004, 32'h1000, 32'h2000, 5'd3};
		x.src = (r.op != OP_RTYPE);
		x.dst = (r.op == OP_RTYPE) || (r.op == OP_JAL);
		x.pc4f = (r.op == OP_JAL);
		{x.mrd, x.mwr, x.lsel, x.m2r, x.rw} = {i[0], i[1], i[2:1], i[2], i[3]};
		return x;
	endfunction

	// =========================================================================
	// stimulus
	// =========================================================================
	initial begin
		rows = '{
			'{OP_RTYPE, 32'h20, 32'h5, 32'h7, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'hc},
			'{OP_RTYPE, 32'h22, 32'h5, 32'h7, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'hfffffffe},
			'{OP_RTYPE, 32'h21, 32'hffffffff, 32'h2, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'h1},
			'{OP_RTYPE, 32'h23, 32'h0, 32'h1, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'hffffffff},
			'{OP_RTYPE, 32'h24, 32'hf0f0ff00, 32'h0ff0f0f0, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0,
				32'h00f0f000},
			'{OP_RTYPE, 32'h25, 32'hf0f0ff00, 32'h0ff0f0f0, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0,
				32'hfff0fff0},
			'{OP_RTYPE, 32'h26, 32'hf0f0ff00, 32'h0ff0f0f0, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0,
				32'hff000ff0},
			'{OP_RTYPE, 32'h27, 32'hf0f0ff00, 32'h0ff0f0f0, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0,
				32'h000f000f},
			'{OP_RTYPE, 32'h2a, 32'hfffffffe, 32'h1, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'h1},
			'{OP_RTYPE, 32'h2b, 32'hfffffffe, 32'h1, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'h0},
			'{OP_RTYPE, 32'h7c0, 32'h0, 32'h3, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'h80000000},
			'{OP_RTYPE, 32'h0, 32'h0, 32'h3, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'h3},
			'{OP_RTYPE, 32'h7c2, 32'h0, 32'h80000000, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'h1},
			'{OP_RTYPE, 32'h103, 32'h0, 32'h80000000, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0,
				32'hf8000000},
			'{OP_RTYPE, 32'h4, 32'h1f, 32'h1, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'h80000000},
			'{OP_RTYPE, 32'h6, 32'h0, 32'h12345678, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0,
				32'h12345678},
			'{OP_RTYPE, 32'h7, 32'h3f, 32'h80000000, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0,
				32'hffffffff},
			'{OP_ADDI, 32'hfffffffb, 32'ha, 32'h0, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'h5},
			'{OP_ADDIU, 32'hffff8000, 32'h8000, 32'h0, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'h0},
			'{OP_SLTI, 32'h1, 32'hfffffff0, 32'h0, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'h1},
			'{OP_SLTIU, 32'h1, 32'hfffffff0, 32'h0, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'h0},
			'{OP_ANDI, 32'hff0f, 32'h12345678, 32'h0, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'h5608},
			'{OP_ORI, 32'hf, 32'h12345678, 32'h0, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'h1234567f},
			'{OP_XORI, 32'hffff, 32'hffff0000, 32'h0, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0,
				32'hffffffff},
			'{OP_LUI, 32'habcd, 32'h9, 32'h0, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'habcd0000},
			'{OP_LW, 32'hfffffffc, 32'h1000, 32'h0, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'hffc},
			'{OP_SW, 32'h8, 32'h2000, 32'hdeadbeef, 5'd1, 5'd2, 5'd0, 1'b0, 5'd2, 1'b1, 32'h2008},
			'{OP_JAL, 32'h0, 32'h55, 32'h0, 5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 1'b0, 32'h1004},
			// forwarding cases from here on
			'{OP_RTYPE, 32'h20, 32'h100, 32'h200, 5'd1, 5'd2, 5'd1, 1'b1, 5'd0, 1'b0, 32'h1200},
			'{OP_RTYPE, 32'h20, 32'h100, 32'h200, 5'd1, 5'd2, 5'd0, 1'b0, 5'd2, 1'b1, 32'h2100},
			'{OP_RTYPE, 32'h20, 32'h100, 32'h200, 5'd1, 5'd2, 5'd1, 1'b1, 5'd1, 1'b1, 32'h1200},
			'{OP_RTYPE, 32'h20, 32'h100, 32'h200, 5'd1, 5'd2, 5'd2, 1'b1, 5'd2, 1'b1, 32'h1100},
			'{OP_RTYPE, 32'h20, 32'h100, 32'h200, 5'd1, 5'd2, 5'd1, 1'b0, 5'd2, 1'b0, 32'h300},
			'{OP_RTYPE, 32'h20, 32'h100, 32'h200, 5'd0, 5'd0, 5'd0, 1'b1, 5'd0, 1'b1, 32'h300}
		};
		i_clk = 1'b0;
		i_nrst = 1'b0;
		apply('0);
		repeat (5) wait_edge(1'b1);
		wait_edge(1'b0);
		check_outputs('0, '0);
		i_nrst = 1'b1;
		#1;
		check_outputs('0, '0);
		wait_edge(1'b0);
		foreach (rows[i]) begin
			v = to_vec(rows[i], i);
			apply(v);
			wait_edge(1'b1);
			wait_edge(1'b0);
			check_outputs(v, rows[i].exp);
		end
		for (int n = 0; n < 200; n++) begin
			v.op = ops[lfsr_bits(4) % 12];
			v.imm = lfsr_bits(32);
			if (v.op == OP_RTYPE)
				v.imm[5:0] = fns[lfsr_bits(4)];
			{v.rs, v.rt, v.pc4, v.md, v.wd} = {lfsr_bits(32), lfsr_bits(32), lfsr_bits(32),
				lfsr_bits(32), lfsr_bits(32)};
			// narrow addresses so forwarding hits are common
			v.rsa = reg_addr_t'(lfsr_bits(2));
			v.rta = reg_addr_t'(lfsr_bits(2));
			v.rda = reg_addr_t'(lfsr_bits(5));
			v.ma = reg_addr_t'(lfsr_bits(2));
			v.wa = reg_addr_t'(lfsr_bits(2));
			{v.mwe, v.wwe, v.src, v.dst, v.pc4f} = 5'(lfsr_bits(5));
			{v.mrd, v.mwr, v.lsel, v.m2r, v.rw} = 6'(lfsr_bits(6));
			apply(v);
			wait_edge(1'b1);
			wait_edge(1'b0);
			check_outputs(v, ref_result(v));
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== mips_execute.f ====
verilog/mips_isa_pkg.sv
verilog/mips_pipe_pkg.sv
verilog/ex_fwd_if.sv
verilog/ex_forward.sv
verilog/ex_operand_sel.sv
verilog/ex_alu_decode.sv
verilog/ex_alu.sv
verilog/mips_execute.sv
verification/mips_execute_chk.sv
verification/tb_mips_execute.sv
